// ==== vlog.f ====
design/mem_pkg.sv
design/mem_ctrl.sv
design/fetch_unit.sv
design/load_store_unit.sv
design/mem_subsys.sv
dv/byte_mem_model.sv
dv/mem_subsys_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = mem_subsys_tb
FILELIST = vlog.f

.PHONY: sim clean

# status comes from grep, so a run without the pass line fails
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "All tests passed" > /dev/null

clean:
	rm -rf obj_dir

// ==== dv/mem_subsys_tb.sv ====
/* Testbench for the memory subsystem: drives fetch and load/store traffic against a byte
   memory model and checks every instruction and load result against a shadow copy. */
`timescale 1ns/1ps

module mem_subsys_tb;

    localparam int mem_bytes          = 131072;
    localparam int n_fetch            = 24;
    localparam int n_redirect         = 8;
    localparam int takes_per_redirect = 5;
    localparam int n_load             = 40;
    localparam int n_store            = 20;
    localparam int n_mixed            = 40;
    // store phase does one store and four readbacks
    localparam int n_ops = n_fetch + n_redirect * (takes_per_redirect + 1) + n_load
                         + 5 * n_store + n_mixed + 8;

    logic                       clk_in;
    logic                       reset;
    logic                       rdy_in;
    logic                       io_buffer_full;
    logic [7:0]                 mem_din;
    logic [7:0]                 mem_dout;
    logic [mem_pkg::addr_w-1:0] mem_a;
    logic                       mem_wr;
    logic                       inst_valid;
    logic [mem_pkg::data_w-1:0] inst;
    logic [mem_pkg::addr_w-1:0] inst_pc;
    logic                       inst_take;
    logic                       redirect;
    logic [mem_pkg::addr_w-1:0] redirect_pc;
    logic                       ls_en;
    mem_pkg::ls_cmd_t           ls_cmd;
    logic                       ls_busy;
    logic                       ls_done;
    logic [mem_pkg::data_w-1:0] ls_data;
    int unsigned                io_count;
    logic [7:0]                 io_byte;

    logic [7:0]                 shadow [0:mem_bytes-1];
    logic [31:0]                seed;
    logic [mem_pkg::addr_w-1:0] exp_pc;
    logic [mem_pkg::data_w-1:0] exp_q [$];
    int                         n_taken;

    mem_subsys #(
        .reset_pc(32'h0000_0000)
    ) mem_subsys_i (
        .clk_in        (clk_in),
        .reset         (reset),
        .rdy_in        (rdy_in),
        .io_buffer_full(io_buffer_full),
        .mem_din       (mem_din),
        .mem_dout      (mem_dout),
        .mem_a         (mem_a),
        .mem_wr        (mem_wr),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .inst_take     (inst_take),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .ls_en         (ls_en),
        .ls_cmd        (ls_cmd),
        .ls_busy       (ls_busy),
        .ls_done       (ls_done),
        .ls_data       (ls_data)
    );

    byte_mem_model byte_mem_model_i (
        .clk_in  (clk_in),
        .reset   (reset),
        .rdy_in  (rdy_in),
        .mem_a   (mem_a),
        .mem_wr  (mem_wr),
        .mem_dout(mem_dout),
        .mem_din (mem_din),
        .io_count(io_count),
        .io_byte (io_byte)
    );

    always #20 clk_in = ~clk_in;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // high bits of the LCG are the useful ones
    task automatic next_random(output logic [31:0] r);
        seed = lcg_next(seed);
        r    = seed ^ (seed >> 16);
    endtask

    function automatic mem_pkg::mem_op_e pick_op(input logic [31:0] r, input logic store);
        logic [2:0] k;
        if (store) begin
            k = 3'd5 + 3'(r % 32'd3);
        end else begin
            k = 3'(r % 32'd5);
        end
        return mem_pkg::mem_op_e'(k);
    endfunction

    function automatic logic [31:0] align_for(input mem_pkg::mem_op_e op, input logic [31:0] a);
        if (op inside {mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh}) begin
            return {a[31:1], 1'b0};
        end else if (op inside {mem_pkg::op_lw, mem_pkg::op_sw}) begin
            return {a[31:2], 2'b00};
        end
        return a;
    endfunction

    // little-endian word from the shadow copy
    function automatic logic [31:0] inst_ref(input logic [31:0] pc);
        return {shadow[pc[16:0] + 17'd3], shadow[pc[16:0] + 17'd2],
                shadow[pc[16:0] + 17'd1], shadow[pc[16:0]]};
    endfunction

    function automatic logic [31:0] load_ref(input mem_pkg::mem_op_e op, input logic [31:0] a);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = shadow[a[16:0]];
        b1 = shadow[a[16:0] + 17'd1];
        case (op)
            mem_pkg::op_lb:  return {{24{b0[7]}}, b0};
            mem_pkg::op_lh:  return {{16{b1[7]}}, b1, b0};
            mem_pkg::op_lw:  return inst_ref(a);
            mem_pkg::op_lbu: return {24'h0, b0};
            mem_pkg::op_lhu: return {16'h0, b1, b0};
            default:         return 32'h0;
        endcase
    endfunction

    task automatic store_ref(input mem_pkg::mem_op_e op, input logic [31:0] a,
                             input logic [31:0] d);
        // I/O bytes never reach memory
        if (a[17:16] != 2'b11) begin
            shadow[a[16:0]] = d[7:0];
            if (op != mem_pkg::op_sb) begin
                shadow[a[16:0] + 17'd1] = d[15:8];
            end
            if (op == mem_pkg::op_sw) begin
                shadow[a[16:0] + 17'd2] = d[23:16];
                shadow[a[16:0] + 17'd3] = d[31:24];
            end
        end
    endtask

    task automatic check_inst(input logic [mem_pkg::data_w-1:0] got_inst,
                              input logic [mem_pkg::addr_w-1:0] got_pc,
                              input logic [mem_pkg::data_w-1:0] want_inst,
                              input logic [mem_pkg::addr_w-1:0] want_pc);
        if (got_pc !== want_pc) begin
            stop_on_error($sformatf("mismatch inst_pc: got %h expected %h", got_pc, want_pc));
        end else if (got_inst !== want_inst) begin
            stop_on_error($sformatf("mismatch inst at pc %h: got %h expected %h",
                                    got_pc, got_inst, want_inst));
        end
    endtask

    task automatic check_load(input logic [mem_pkg::data_w-1:0] got,
                              input logic [mem_pkg::data_w-1:0] want);
        if (got !== want) begin
            stop_on_error($sformatf("mismatch ls_data: got %h expected %h", got, want));
        end
    endtask

    task automatic check_io(input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            stop_on_error($sformatf("mismatch io_byte: got %h expected %h", got, want));
        end
    endtask

    // compares every taken instruction and every ls_done
    always @(posedge clk_in) begin
        if (!reset && rdy_in) begin
            if (inst_valid && inst_take) begin
                check_inst(inst, inst_pc, inst_ref(exp_pc), exp_pc);
                exp_pc  = exp_pc + 32'd4;
                n_taken = n_taken + 1;
            end
            if (redirect) begin
                exp_pc = redirect_pc;
            end
            if (ls_done) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("ls_done pulsed with no load or store outstanding");
                end else begin
                    check_load(ls_data, exp_q.pop_front());
                end
            end
        end
    end

    task automatic issue_ls(input mem_pkg::mem_op_e op, input logic [31:0] a,
                            input logic [31:0] d);
        while (ls_busy) @(negedge clk_in);
        ls_en       = 1'b1;
        ls_cmd.op   = op;
        ls_cmd.addr = a;
        ls_cmd.data = d;
        if (op inside {mem_pkg::op_sb, mem_pkg::op_sh, mem_pkg::op_sw}) begin
            exp_q.push_back(32'h0);
            store_ref(op, a, d);
        end else begin
            exp_q.push_back(load_ref(op, a));
        end
        @(negedge clk_in);
        ls_en = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) @(negedge clk_in);
    endtask

    task automatic run_ls(input mem_pkg::mem_op_e op, input logic [31:0] a,
                          input logic [31:0] d);
        issue_ls(op, a, d);
        wait_idle();
    endtask

    task automatic wait_takes(input int n);
        int target;
        target = n_taken + n;
        while (n_taken < target) @(negedge clk_in);
    endtask

    task automatic send_redirect(input logic [31:0] pc);
        redirect    = 1'b1;
        redirect_pc = pc;
        @(negedge clk_in);
        redirect = 1'b0;
    endtask

    // bus must hold still while rdy_in stays low for ten cycles
    task automatic hold_pause(input int lead);
        logic [mem_pkg::addr_w-1:0] held_a;
        logic                       held_wr;
        repeat (lead) @(negedge clk_in);
        rdy_in  = 1'b0;
        held_a  = mem_a;
        held_wr = mem_wr;
        repeat (10) begin
            @(negedge clk_in);
            if (mem_a !== held_a) begin
                stop_on_error($sformatf("mismatch mem_a: got %h expected %h", mem_a, held_a));
            end else if (mem_wr !== held_wr) begin
                stop_on_error($sformatf("mismatch mem_wr: got %h expected %h", mem_wr, held_wr));
            end
        end
        rdy_in = 1'b1;
    endtask

    initial begin
        #(n_ops * 40 * 40);
        stop_on_error("timeout, the tests did not finish in the expected time");
    end

    initial begin
        logic [31:0]      r;
        logic [31:0]      a;
        logic [31:0]      d;
        int unsigned      io_before;
        int               taken_before;
        mem_pkg::mem_op_e op;

        clk_in         = 1'b0;
        reset          = 1'b1;
        rdy_in         = 1'b1;
        io_buffer_full = 1'b0;
        inst_take      = 1'b0;
        redirect       = 1'b0;
        redirect_pc    = '0;
        ls_en          = 1'b0;
        ls_cmd         = '0;
        seed           = 32'h58cc;
        exp_pc         = 32'h0;
        n_taken        = 0;
        for (int i = 0; i < mem_bytes; i++) begin
            next_random(r);
            shadow[i] = r[7:0];
            byte_mem_model_i.preload(17'(i), r[7:0]);
        end
        repeat (4) @(negedge clk_in);
        reset = 1'b0;
        if (mem_wr !== 1'b0 || inst_valid !== 1'b0 || ls_busy !== 1'b0 || ls_done !== 1'b0) begin
            stop_on_error("outputs were not cleared by reset");
        end

        // sequential fetch from reset_pc
        inst_take = 1'b1;
        wait_takes(n_fetch);
        for (int k = 0; k < n_redirect; k++) begin
            next_random(r);
            repeat (r % 8) @(negedge clk_in);
            next_random(r);
            send_redirect({18'd0, r[13:2], 2'b00});
            wait_takes(takes_per_redirect);
        end

        // loads alone while the full buffer keeps fetch quiet
        inst_take = 1'b0;
        for (int k = 0; k < n_load; k++) begin
            next_random(r);
            op = pick_op(r, 1'b0);
            next_random(r);
            run_ls(op, align_for(op, {15'd0, r[16:0]}), 32'd0);
        end

        // stores land above 0x10000, away from the fetch stream
        for (int k = 0; k < n_store; k++) begin
            next_random(r);
            op = pick_op(r, 1'b1);
            next_random(r);
            a = align_for(op, {15'd0, 1'b1, r[15:0]});
            next_random(d);
            run_ls(op, a, d);
            run_ls(mem_pkg::op_lw, {a[31:2], 2'b00}, 32'd0);
            run_ls(mem_pkg::op_lb, a, 32'd0);
            run_ls(mem_pkg::op_lhu, {a[31:2], 2'b10}, 32'd0);
            run_ls(mem_pkg::op_lbu, {a[31:2] + 30'd1, 2'b00}, 32'd0);
        end

        // contention with fetch running
        inst_take    = 1'b1;
        taken_before = n_taken;
        for (int k = 0; k < n_mixed; k++) begin
            next_random(r);
            op = pick_op(r, r[24]);
            next_random(a);
            if (r[24]) begin
                a = {15'd0, 1'b1, a[15:0]};
            end else begin
                a = {15'd0, a[16:0]};
            end
            next_random(d);
            run_ls(op, align_for(op, a), d);
        end
        if (n_taken == taken_before) begin
            stop_on_error("fetch made no progress while loads and stores ran");
        end

        // I/O byte held back by io_buffer_full
        inst_take = 1'b0;
        while (!inst_valid) @(negedge clk_in);
        @(negedge clk_in);
        io_buffer_full = 1'b1;
        io_before      = io_count;
        next_random(d);
        issue_ls(mem_pkg::op_sb, 32'h0003_0000, d);
        repeat (20) begin
            @(negedge clk_in);
            if (mem_wr !== 1'b0) begin
                stop_on_error("mem_wr went high while io_buffer_full was high");
            end
        end
        if (exp_q.size() == 0) begin
            stop_on_error("I/O store finished while io_buffer_full was high");
        end
        io_buffer_full = 1'b0;
        wait_idle();
        repeat (10) @(negedge clk_in);
        if (io_count != io_before + 32'd1) begin
            stop_on_error($sformatf("mismatch io_count: got %h expected %h",
                                    io_count, io_before + 32'd1));
        end
        check_io(io_byte, d[7:0]);

        // pause in the middle of a load, then of a store
        inst_take = 1'b1;
        next_random(r);
        issue_ls(mem_pkg::op_lw, {15'd0, r[16:2], 2'b00}, 32'd0);
        hold_pause(3);
        wait_idle();
        // fetch parked on a full buffer so the store owns the bus
        inst_take = 1'b0;
        while (!inst_valid) @(negedge clk_in);
        next_random(r);
        next_random(d);
        a = {15'd0, 1'b1, r[15:2], 2'b00};
        issue_ls(mem_pkg::op_sw, a, d);
        hold_pause(2);
        wait_idle();
        run_ls(mem_pkg::op_lw, a, 32'd0);

        repeat (4) @(negedge clk_in);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== dv/byte_mem_model.sv ====
/* Byte-wide memory for the testbench, 128 KB with registered reads and an I/O output log.
   Honors rdy_in like the core, so a paused bus neither writes nor advances the read data. */
`timescale 1ns/1ps

module byte_mem_model (
    input  logic        clk_in,
    input  logic        reset,
    input  logic        rdy_in,
    input  logic [31:0] mem_a,
    input  logic        mem_wr,
    input  logic [7:0]  mem_dout,
    output logic [7:0]  mem_din,
    output int unsigned io_count,
    output logic [7:0]  io_byte
);

    logic [7:0] mem [0:131071];
    logic       is_io;

    // bits 17:16 both set selects the I/O window
    assign is_io = (mem_a[17:16] == 2'b11);

    always @(posedge clk_in) begin
        if (reset) begin
            mem_din  <= 8'h00;
            io_count <= 0;
            io_byte  <= 8'h00;
        end else if (rdy_in) begin
            if (mem_wr) begin
                if (is_io) begin
                    // output log keeps a count and the last byte
                    io_count <= io_count + 32'd1;
                    io_byte  <= mem_dout;
                end else begin
                    mem[mem_a[16:0]] <= mem_dout;
                end
            end
            // data for this address shows up next cycle
            mem_din <= is_io ? 8'h00 : mem[mem_a[16:0]];
        end
    end

    // fills one byte before the run starts
    task automatic preload(input logic [16:0] a, input logic [7:0] d);
        mem[a] = d;
    endtask

endmodule

// ==== design/mem_subsys.sv ====
/* Top of the memory subsystem: fetch unit and load/store unit sharing
   the byte-wide external memory port through the controller. */
`timescale 1ns/1ps

module mem_subsys #(
    parameter logic [mem_pkg::addr_w-1:0] reset_pc = '0
) (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       rdy_in,
    input  logic                       io_buffer_full,
    input  logic [7:0]                 mem_din,
    output logic [7:0]                 mem_dout,
    output logic [mem_pkg::addr_w-1:0] mem_a,
    output logic                       mem_wr,
    // fetch side
    output logic                       inst_valid,
    output logic [mem_pkg::data_w-1:0] inst,
    output logic [mem_pkg::addr_w-1:0] inst_pc,
    input  logic                       inst_take,
    input  logic                       redirect,
    input  logic [mem_pkg::addr_w-1:0] redirect_pc,
    // load/store side
    input  logic                       ls_en,
    input  mem_pkg::ls_cmd_t           ls_cmd,
    output logic                       ls_busy,
    output logic                       ls_done,
    output logic [mem_pkg::data_w-1:0] ls_data
);

    logic              if_valid;
    mem_pkg::mem_req_t if_req;
    mem_pkg::mem_rsp_t if_rsp;
    logic              lsu_valid;
    mem_pkg::mem_req_t lsu_req;
    mem_pkg::mem_rsp_t lsu_rsp;

    fetch_unit #(
        .reset_pc(reset_pc)
    ) fetch_unit_i (
        .clk_in     (clk_in),
        .reset      (reset),
        .rdy_in     (rdy_in),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .inst_take  (inst_take),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .mem_valid  (if_valid),
        .mem_req    (if_req),
        .mem_rsp    (if_rsp)
    );

    load_store_unit load_store_unit_i (
        .clk_in   (clk_in),
        .reset    (reset),
        .rdy_in   (rdy_in),
        .ls_en    (ls_en),
        .ls_cmd   (ls_cmd),
        .ls_busy  (ls_busy),
        .ls_done  (ls_done),
        .ls_data  (ls_data),
        .mem_valid(lsu_valid),
        .mem_req  (lsu_req),
        .mem_rsp  (lsu_rsp)
    );

    mem_ctrl mem_ctrl_i (
        .clk_in        (clk_in),
        .reset         (reset),
        .rdy_in        (rdy_in),
        .io_buffer_full(io_buffer_full),
        .mem_din       (mem_din),
        .mem_dout      (mem_dout),
        .mem_a         (mem_a),
        .mem_wr        (mem_wr),
        .if_valid      (if_valid),
        .if_req        (if_req),
        .if_rsp        (if_rsp),
        .ls_valid      (lsu_valid),
        .ls_req        (lsu_req),
        .ls_rsp        (lsu_rsp)
    );

endmodule

// ==== design/load_store_unit.sv ====
/* Single-entry load/store unit. Turns an RV32I load or store into one controller
   transfer and returns the extended load value with a done pulse. */
`timescale 1ns/1ps

module load_store_unit (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       rdy_in,
    input  logic                       ls_en,
    input  mem_pkg::ls_cmd_t           ls_cmd,
    output logic                       ls_busy,
    output logic                       ls_done,
    output logic [mem_pkg::data_w-1:0] ls_data,
    output logic                       mem_valid,
    output mem_pkg::mem_req_t          mem_req,
    input  mem_pkg::mem_rsp_t          mem_rsp
);

    mem_pkg::ls_cmd_t           cmd_q;
    logic                       busy;
    logic                       done_q;
    logic [mem_pkg::data_w-1:0] data_q;
    logic [mem_pkg::data_w-1:0] load_val;

    assign ls_busy   = busy;
    assign mem_valid = busy;
    // done pulse only shows in an active cycle
    assign ls_done   = done_q && rdy_in;
    assign ls_data   = data_q;

    // opcode to direction and length
    always_comb begin
        mem_req.addr  = cmd_q.addr;
        mem_req.wdata = cmd_q.data;
        case (cmd_q.op)
            mem_pkg::op_lb, mem_pkg::op_lbu: begin
                mem_req.write = 1'b0;
                mem_req.len   = mem_pkg::len_one;
            end
            mem_pkg::op_lh, mem_pkg::op_lhu: begin
                mem_req.write = 1'b0;
                mem_req.len   = mem_pkg::len_two;
            end
            mem_pkg::op_sb: begin
                mem_req.write = 1'b1;
                mem_req.len   = mem_pkg::len_one;
            end
            mem_pkg::op_sh: begin
                mem_req.write = 1'b1;
                mem_req.len   = mem_pkg::len_two;
            end
            mem_pkg::op_sw: begin
                mem_req.write = 1'b1;
                mem_req.len   = mem_pkg::len_four;
            end
            default: begin
                mem_req.write = 1'b0;
                mem_req.len   = mem_pkg::len_four;
            end
        endcase
    end

    // controller data is already zero-extended
    always_comb begin
        case (cmd_q.op)
            mem_pkg::op_lb:  load_val = {{24{mem_rsp.rdata[7]}}, mem_rsp.rdata[7:0]};
            mem_pkg::op_lh:  load_val = {{16{mem_rsp.rdata[15]}}, mem_rsp.rdata[15:0]};
            mem_pkg::op_lw, mem_pkg::op_lbu, mem_pkg::op_lhu: begin
                load_val = mem_rsp.rdata;
            end
            default:         load_val = '0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            busy   <= 1'b0;
            done_q <= 1'b0;
            data_q <= '0;
        end else if (rdy_in) begin
            done_q <= 1'b0;
            if (!busy && ls_en) begin
                busy  <= 1'b1;
                cmd_q <= ls_cmd;
            end
            if (busy && mem_rsp.done) begin
                busy   <= 1'b0;
                done_q <= 1'b1;
                data_q <= load_val;
            end
        end
    end

endmodule

// ==== design/fetch_unit.sv ====
/* Sequential instruction fetcher with a one-entry buffer.
   Reads 32-bit words through the memory controller and follows redirects. */
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [mem_pkg::addr_w-1:0] reset_pc = '0
) (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       rdy_in,
    input  logic                       redirect,
    input  logic [mem_pkg::addr_w-1:0] redirect_pc,
    input  logic                       inst_take,
    output logic                       inst_valid,
    output logic [mem_pkg::data_w-1:0] inst,
    output logic [mem_pkg::addr_w-1:0] inst_pc,
    output logic                       mem_valid,
    output mem_pkg::mem_req_t          mem_req,
    input  mem_pkg::mem_rsp_t          mem_rsp
);

    logic [mem_pkg::addr_w-1:0] pc;
    logic [mem_pkg::addr_w-1:0] req_addr;
    logic                       busy;
    logic                       discard;
    logic                       buf_valid;
    logic [mem_pkg::data_w-1:0] buf_inst;
    logic [mem_pkg::addr_w-1:0] buf_pc;

    assign inst_valid = buf_valid;
    assign inst       = buf_inst;
    assign inst_pc    = buf_pc;
    assign mem_valid  = busy;

    // always a four-byte read
    always_comb begin
        mem_req.write = 1'b0;
        mem_req.len   = mem_pkg::len_four;
        mem_req.addr  = req_addr;
        mem_req.wdata = '0;
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            pc        <= reset_pc;
            busy      <= 1'b0;
            discard   <= 1'b0;
            buf_valid <= 1'b0;
        end else if (rdy_in) begin
            // start only with an empty buffer
            if (!busy && !buf_valid && !redirect) begin
                busy     <= 1'b1;
                req_addr <= pc;
            end

            if (buf_valid && inst_take) begin
                buf_valid <= 1'b0;
            end

            if (mem_rsp.done) begin
                busy    <= 1'b0;
                discard <= 1'b0;
                if (!discard && !redirect) begin
                    buf_valid <= 1'b1;
                    buf_inst  <= mem_rsp.rdata;
                    buf_pc    <= req_addr;
                    pc        <= req_addr + 32'd4;
                end
            end

            // redirect flushes the buffer and any fetch in flight
            if (redirect) begin
                pc        <= redirect_pc;
                buf_valid <= 1'b0;
                if (busy && !mem_rsp.done) begin
                    discard <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/mem_ctrl.sv ====
/* Arbitrates fetch and load/store requests onto the byte-wide memory port
   and sequences each transfer one byte per cycle, little-endian. */
`timescale 1ns/1ps

module mem_ctrl (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       rdy_in,
    input  logic                       io_buffer_full,
    input  logic [7:0]                 mem_din,
    output logic [7:0]                 mem_dout,
    output logic [mem_pkg::addr_w-1:0] mem_a,
    output logic                       mem_wr,
    input  logic                       if_valid,
    input  mem_pkg::mem_req_t          if_req,
    output mem_pkg::mem_rsp_t          if_rsp,
    input  logic                       ls_valid,
    input  mem_pkg::mem_req_t          ls_req,
    output mem_pkg::mem_rsp_t          ls_rsp
);

    mem_pkg::ctrl_state_e       state;
    logic                       owner_ls;
    mem_pkg::mem_req_t          req_q;
    logic [2:0]                 idx;
    logic [1:0]                 got;
    logic                       addr_live;
    logic                       data_live;
    logic [mem_pkg::data_w-1:0] shift_q;

    logic [2:0]                 nbytes;
    logic [mem_pkg::addr_w-1:0] issue_addr;
    logic [7:0]                 wbyte;
    logic                       io_stall;
    logic [mem_pkg::data_w-1:0] rdata;
    logic                       done;

    always_comb begin
        case (req_q.len)
            mem_pkg::len_one: nbytes = 3'd1;
            mem_pkg::len_two: nbytes = 3'd2;
            default:          nbytes = 3'd4;
        endcase
    end

    assign issue_addr = req_q.addr + {{(mem_pkg::addr_w - 3){1'b0}}, idx};
    assign wbyte      = req_q.wdata[{idx[1:0], 3'b000} +: 8];
    // uart output must wait for room
    assign io_stall   = req_q.write && (issue_addr[17:16] == mem_pkg::io_sel) && io_buffer_full;

    // bytes shift in from the top, so short reads sit high
    always_comb begin
        case (nbytes)
            3'd1:    rdata = {24'd0, shift_q[31:24]};
            3'd2:    rdata = {16'd0, shift_q[31:16]};
            default: rdata = shift_q;
        endcase
    end

    // no done while paused
    assign done = (state == mem_pkg::st_finish) && rdy_in;

    always_comb begin
        if_rsp.done  = done && !owner_ls;
        if_rsp.rdata = rdata;
        ls_rsp.done  = done && owner_ls;
        ls_rsp.rdata = rdata;
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state     <= mem_pkg::st_idle;
            owner_ls  <= 1'b0;
            idx       <= 3'd0;
            got       <= 2'd0;
            addr_live <= 1'b0;
            data_live <= 1'b0;
            mem_a     <= '0;
            mem_wr    <= 1'b0;
        end else if (rdy_in) begin
            case (state)
                mem_pkg::st_idle: begin
                    idx       <= 3'd0;
                    got       <= 2'd0;
                    addr_live <= 1'b0;
                    data_live <= 1'b0;
                    // load/store has priority
                    if (ls_valid) begin
                        owner_ls <= 1'b1;
                        req_q    <= ls_req;
                        state    <= mem_pkg::st_transfer;
                    end else if (if_valid) begin
                        owner_ls <= 1'b0;
                        req_q    <= if_req;
                        state    <= mem_pkg::st_transfer;
                    end
                end
                mem_pkg::st_transfer: begin
                    data_live <= addr_live;
                    if (idx != nbytes) begin
                        mem_a <= issue_addr;
                        if (io_stall) begin
                            // same address again, no write
                            mem_wr    <= 1'b0;
                            addr_live <= 1'b0;
                        end else begin
                            mem_wr    <= req_q.write;
                            mem_dout  <= wbyte;
                            addr_live <= !req_q.write;
                            idx       <= idx + 3'd1;
                        end
                    end else begin
                        mem_wr    <= 1'b0;
                        addr_live <= 1'b0;
                        if (req_q.write) begin
                            state <= mem_pkg::st_finish;
                        end
                    end
                    // read byte returns one cycle after its address
                    if (data_live) begin
                        shift_q <= {mem_din, shift_q[31:8]};
                        got     <= got + 2'd1;
                        if ({1'b0, got} == nbytes - 3'd1) begin
                            state <= mem_pkg::st_finish;
                        end
                    end
                end
                mem_pkg::st_finish: begin
                    state <= mem_pkg::st_idle;
                end
                default: begin
                    state <= mem_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

// ==== design/mem_pkg.sv ====
/* Shared widths, address map, enums and request/response structs for the memory subsystem.
   Modules refer to these by scoped names. */
package mem_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;

    // bits 17:16 of an I/O address
    localparam logic [1:0] io_sel = 2'b11;

    // RV32I load/store opcodes
    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_lbu = 3'd3,
        op_lhu = 3'd4,
        op_sb  = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } mem_op_e;

    // bytes moved by one transfer
    typedef enum logic [1:0] {
        len_one  = 2'd0,
        len_two  = 2'd1,
        len_four = 2'd2
    } len_e;

    typedef enum logic [1:0] {
        st_idle     = 2'd0,
        st_transfer = 2'd1,
        st_finish   = 2'd2
    } ctrl_state_e;

    // requester to controller, held until done
    typedef struct packed {
        logic              write;
        len_e              len;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } mem_req_t;

    // controller to requester, rdata zero-extended
    typedef struct packed {
        logic              done;
        logic [data_w-1:0] rdata;
    } mem_rsp_t;

    // command from the core into the load/store unit
    typedef struct packed {
        mem_op_e           op;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } ls_cmd_t;

endpackage
